/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing -j 0
TOP      = tb_uart
FILELIST = list.f
BUILD    = obj_dir
LOG      = sim.log
FAIL_MSG = Simulation failed
PASS_MSG = Simulation completed successfully

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "test FAILED, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "test FAILED, no result in $(LOG)"; exit 1; \
	fi
	@echo "test PASSED"

clean:
	rm -rf $(BUILD) $(LOG)

/* list.f */
rtl/uart_pkg.sv
rtl/wb_pkg.sv
rtl/uart_wb_regs.sv
rtl/uart_tx_fifo.sv
rtl/uart_txd.sv
rtl/uart_top.sv
sim/uart_monitor.sv
sim/tb_uart.sv

/* rtl/uart_pkg.sv */
package uart_pkg;

	// --------------------------------------------------
	// serial side types
	// --------------------------------------------------

	// one character on the wire
	typedef logic [7:0] uart_byte_t;

	// position inside a frame, 0 is the start bit
	typedef logic [3:0] uart_bit_cnt_t;

	// start + 8 data + 1 stop
	localparam uart_bit_cnt_t uart_frame_bits = 4'd10;

	// --------------------------------------------------
	// transmitter fsm
	// --------------------------------------------------

	typedef enum logic [1:0] {
		tx_idle  = 2'd0,	// line high, waiting for a request
		tx_latch = 2'd1,	// capture the byte
		tx_send  = 2'd2	// shifting the frame out
	} tx_state_t;

endpackage

/* rtl/uart_top.sv */
`timescale 1ns/1ps

module uart_top import wb_pkg::*, uart_pkg::*; #(
	parameter int CLK_DIV    = 434,	// cycles per bit
	parameter int FIFO_DEPTH = 8	// transmit queue slots
) (
	input  logic     SYS_CLK,
	input  logic     RST_N,
	input  logic     wb_cyc,
	input  logic     wb_stb,
	input  logic     wb_we,
	input  wb_addr_t wb_adr,
	input  wb_data_t wb_dat_w,
	output wb_data_t wb_dat_r,
	output logic     wb_ack,
	output logic     txd
);

	// --------------------------------------------------
	// internal nets
	// --------------------------------------------------

	logic       push;	// regs to fifo
	uart_byte_t push_data;
	logic       full;	// fifo to regs
	logic       empty;
	logic       tx_req;	// fifo to serializer
	uart_byte_t tx_data;
	logic       tx_ready;	// serializer to fifo
	logic       tx_busy;	// serializer to regs

	uart_wb_regs u_regs (
		.SYS_CLK   (SYS_CLK),
		.RST_N     (RST_N),
		.wb_cyc    (wb_cyc),
		.wb_stb    (wb_stb),
		.wb_we     (wb_we),
		.wb_adr    (wb_adr),
		.wb_dat_w  (wb_dat_w),
		.full      (full),
		.empty     (empty),
		.tx_busy   (tx_busy),
		.wb_dat_r  (wb_dat_r),
		.wb_ack    (wb_ack),
		.push      (push),
		.push_data (push_data)
	);

	uart_tx_fifo #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) u_fifo (
		.SYS_CLK   (SYS_CLK),
		.RST_N     (RST_N),
		.push      (push),
		.push_data (push_data),
		.tx_ready  (tx_ready),
		.full      (full),
		.empty     (empty),
		.tx_req    (tx_req),
		.tx_data   (tx_data)
	);

	uart_txd #(
		.CLK_DIV (CLK_DIV)
	) u_txd (
		.SYS_CLK  (SYS_CLK),
		.RST_N    (RST_N),
		.tx_req   (tx_req),
		.tx_data  (tx_data),
		.txd      (txd),
		.tx_ready (tx_ready),
		.tx_busy  (tx_busy)
	);

endmodule

/* rtl/uart_tx_fifo.sv */
`timescale 1ns/1ps

module uart_tx_fifo import uart_pkg::*; #(
	parameter int FIFO_DEPTH = 8	// power of two
) (
	input  logic       SYS_CLK,
	input  logic       RST_N,
	input  logic       push,
	input  uart_byte_t push_data,
	input  logic       tx_ready,	// serializer idle
	output logic       full,
	output logic       empty,
	output logic       tx_req,	// one cycle pulse
	output uart_byte_t tx_data	// held until next request
);

	localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

	// --------------------------------------------------
	// storage and pointers
	// --------------------------------------------------

	uart_byte_t       mem [FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;	// wraps on its own
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0]   count;	// one extra bit for full
	logic             pop;

	assign full  = (count == (PTR_W+1)'(FIFO_DEPTH));
	assign empty = (count == '0);

	// skip a cycle after each request so ready can drop
	assign pop = ~empty & tx_ready & ~tx_req;

	always_ff @(posedge SYS_CLK) begin
		if (push) begin
			mem[wr_ptr] <= push_data;
		end
		if (pop) begin
			tx_data <= mem[rd_ptr];	// head byte goes out with req
		end
	end

	always_ff @(posedge SYS_CLK or negedge RST_N) begin
		if (!RST_N) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
			tx_req <= 1'b0;
		end else begin
			tx_req <= pop;
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;	// none or both
			endcase
		end
	end

endmodule

/* rtl/uart_txd.sv */
`timescale 1ns/1ps

module uart_txd import uart_pkg::*; #(
	parameter int CLK_DIV = 434	// clock cycles per bit
) (
	input  logic       SYS_CLK,
	input  logic       RST_N,
	input  logic       tx_req,
	input  uart_byte_t tx_data,
	output logic       txd,	// serial line, idles high
	output logic       tx_ready,
	output logic       tx_busy
);

	localparam int CNT_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;
	localparam logic [CNT_W-1:0] CNT_END = CNT_W'(CLK_DIV - 1);

	tx_state_t        state;
	tx_state_t        state_n;
	logic [CNT_W-1:0] baud_cnt;
	logic             baud_wrap;	// last cycle of a bit
	uart_bit_cnt_t    bit_cnt;	// 0 start, 1..8 data, 9 stop
	uart_byte_t       tx_byte;	// captured character

	// level of a given frame position
	function automatic logic frame_bit(input uart_bit_cnt_t pos, input uart_byte_t data);
		logic b;
		if (pos == '0) begin
			b = 1'b0;	// start
		end else if (pos <= 4'd8) begin
			b = data[3'(pos - 4'd1)];	// lsb first
		end else begin
			b = 1'b1;	// stop
		end
		return b;
	endfunction

	// --------------------------------------------------
	// baud and bit counters
	// --------------------------------------------------

	assign baud_wrap = (state == tx_send) && (baud_cnt == CNT_END);

	always_ff @(posedge SYS_CLK or negedge RST_N) begin
		if (!RST_N) begin
			baud_cnt <= '0;
			bit_cnt  <= '0;
		end else if (state == tx_send) begin
			if (baud_wrap) begin
				baud_cnt <= '0;
				bit_cnt  <= bit_cnt + 1'b1;	// next frame position
			end else begin
				baud_cnt <= baud_cnt + 1'b1;
			end
		end else begin
			baud_cnt <= '0;	// only counts while sending
			bit_cnt  <= '0;
		end
	end

	// --------------------------------------------------
	// state machine
	// --------------------------------------------------

	always_ff @(posedge SYS_CLK or negedge RST_N) begin
		if (!RST_N) begin
			state <= tx_idle;
		end else begin
			state <= state_n;
		end
	end

	always_comb begin
		case (state)
			tx_idle:  state_n = tx_req ? tx_latch : tx_idle;
			tx_latch: state_n = tx_send;
			tx_send: begin
				if (baud_wrap && (bit_cnt == uart_frame_bits - 4'd1)) begin
					state_n = tx_idle;	// stop bit done
				end else begin
					state_n = tx_send;
				end
			end
			default:  state_n = tx_idle;
		endcase
	end

	// --------------------------------------------------
	// data capture and line driver
	// --------------------------------------------------

	always_ff @(posedge SYS_CLK) begin
		if (state == tx_latch) begin
			tx_byte <= tx_data;	// fifo holds it through latch
		end
	end

	always_ff @(posedge SYS_CLK or negedge RST_N) begin
		if (!RST_N) begin
			txd <= 1'b1;
		end else if (state_n != tx_send) begin
			txd <= 1'b1;	// idle line
		end else if (state != tx_send) begin
			txd <= 1'b0;	// entering send, start bit
		end else if (baud_wrap) begin
			txd <= frame_bit(bit_cnt + 1'b1, tx_byte);	// load next bit
		end
	end

	assign tx_ready = (state == tx_idle);
	assign tx_busy  = (state != tx_idle);	// latch through stop

endmodule

/* rtl/uart_wb_regs.sv */
`timescale 1ns/1ps

module uart_wb_regs import wb_pkg::*, uart_pkg::*; (
	input  logic       SYS_CLK,
	input  logic       RST_N,
	input  logic       wb_cyc,
	input  logic       wb_stb,
	input  logic       wb_we,
	input  wb_addr_t   wb_adr,
	input  wb_data_t   wb_dat_w,
	input  logic       full,	// fifo back-pressure
	input  logic       empty,
	input  logic       tx_busy,
	output wb_data_t   wb_dat_r,
	output logic       wb_ack,
	output logic       push,	// one cycle, same as ack
	output uart_byte_t push_data
);

	// --------------------------------------------------
	// request decode
	// --------------------------------------------------

	logic     req;	// cyc and stb together
	logic     wr_tx;	// write aimed at the txdata slot
	logic     go;	// answer this request now
	logic     served;	// already acked, wait for stb low
	wb_data_t status;	// assembled status word
	wb_data_t rd_data;	// read mux output

	assign req   = wb_cyc & wb_stb;
	assign wr_tx = wb_we & (wb_adr == reg_txdata);

	// hold off a txdata write while the fifo is full
	assign go = req & ~served & ~(wr_tx & full);

	// --------------------------------------------------
	// read data
	// --------------------------------------------------

	always_comb begin
		status             = '0;
		status[stat_empty] = empty;
		status[stat_full]  = full;
		status[stat_busy]  = tx_busy;
	end

	// unmapped and write only slots read back zero
	assign rd_data = (wb_adr == reg_status) ? status : '0;

	// --------------------------------------------------
	// handshake
	// --------------------------------------------------

	always_ff @(posedge SYS_CLK or negedge RST_N) begin
		if (!RST_N) begin
			wb_ack <= 1'b0;
			served <= 1'b0;
			push   <= 1'b0;
		end else begin
			wb_ack <= go;	// exactly one cycle
			push   <= go & wr_tx;	// lands with ack
			if (req) begin
				served <= served | go;
			end else begin
				served <= 1'b0;	// stb dropped, rearm
			end
		end
	end

	// payload, only meaningful alongside ack or push
	always_ff @(posedge SYS_CLK) begin
		if (go) begin
			wb_dat_r  <= wb_we ? '0 : rd_data;
			push_data <= wb_dat_w[7:0];	// low byte only
		end
	end

endmodule

/* rtl/wb_pkg.sv */
package wb_pkg;

	// --------------------------------------------------
	// bus widths
	// --------------------------------------------------

	typedef logic [1:0]  wb_addr_t;	// word address, four slots
	typedef logic [31:0] wb_data_t;	// bus word

	// --------------------------------------------------
	// register map
	// --------------------------------------------------

	localparam wb_addr_t reg_txdata = 2'd0;	// write only, low byte queued
	localparam wb_addr_t reg_status = 2'd1;	// read only

	// status word bit positions
	localparam int stat_empty = 0;	// fifo has nothing queued
	localparam int stat_full  = 1;	// fifo cannot take a byte
	localparam int stat_busy  = 2;	// serializer mid frame

endpackage

/* sim/tb_uart.sv */
`timescale 1ns/1ps

module tb_uart import uart_pkg::*, wb_pkg::*; ();

	localparam int CLK_DIV      = 8;
	localparam int FIFO_DEPTH   = 4;
	localparam int N_TESTS      = 17;
	localparam int FRAME_CYCLES = int'(uart_frame_bits) * CLK_DIV + 20;
	localparam int CYCLE_LIMIT  = N_TESTS * FRAME_CYCLES;
	localparam wb_data_t ST_IDLE = wb_data_t'(1 << stat_empty);	// empty and not busy

	typedef enum {
		op_line_idle, op_wr_tx, op_wr_rand, op_wr_other, op_rd_status, op_rd_active, op_rd_other,
		op_drain
	} op_t;

	logic     SYS_CLK;
	logic     RST_N;
	logic     wb_cyc;
	logic     wb_stb;
	logic     wb_we;
	wb_addr_t wb_adr;
	wb_data_t wb_dat_w;
	wb_data_t wb_dat_r;
	logic     wb_ack;
	logic     txd;

	string       test_name [N_TESTS];
	op_t         test_op   [N_TESTS];
	wb_data_t    test_val  [N_TESTS];	// byte to send or word to read
	logic [15:0] lfsr        = 16'd37;
	int          cycle_count = 0;

	uart_top #(.CLK_DIV(CLK_DIV), .FIFO_DEPTH(FIFO_DEPTH)) dut (
		.SYS_CLK(SYS_CLK), .RST_N(RST_N), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
		.wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack), .txd(txd)
	);

	uart_monitor #(.CLK_DIV(CLK_DIV)) mon (
		.SYS_CLK(SYS_CLK), .txd(txd), .wb_ack(wb_ack), .wb_we(wb_we), .wb_dat_r(wb_dat_r)
	);

	initial begin
		SYS_CLK = 1'b0;
		forever #20 SYS_CLK = ~SYS_CLK;	// 40 ns period
	end

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic random_byte(output uart_byte_t b);
		b = '0;
		for (int k = 0; k < 8; k++) begin
			lfsr = lfsr_next(lfsr);
			b    = {b[6:0], lfsr[0]};	// one step per bit
		end
	endtask

	task automatic set_entry(input int idx, input string name, input op_t op, input wb_data_t v);
		test_name[idx] = name;
		test_op[idx]   = op;
		test_val[idx]  = v;
	endtask

	// --------------------------------------------------
	// stimulus table
	// --------------------------------------------------

	task automatic load_table();
		set_entry(0, "reset_txd_high", op_line_idle, '0);
		set_entry(1, "reset_status", op_rd_status, ST_IDLE);
		set_entry(2, "tx_0x55", op_wr_tx, 32'h55);
		set_entry(3, "busy_after_0x55", op_rd_active, '0);
		set_entry(4, "idle_after_0x55", op_drain, ST_IDLE);
		set_entry(5, "tx_0xa3", op_wr_tx, 32'ha3);
		set_entry(6, "busy_after_0xa3", op_rd_active, '0);
		set_entry(7, "idle_after_0xa3", op_drain, ST_IDLE);
		for (int k = 0; k < 6; k++) begin
			set_entry(8 + k, $sformatf("burst_%0d", k), op_wr_rand, '0);	// overruns depth 4
		end
		set_entry(14, "idle_after_burst", op_drain, ST_IDLE);
		set_entry(15, "read_offset3", op_rd_other, '0);
		set_entry(16, "write_offset2", op_wr_other, 32'hc3);
	endtask

	// classic cycle held until ack with we left in place afterwards
	task automatic bus_cycle(input logic we, input wb_addr_t adr, input wb_data_t data);
		@(negedge SYS_CLK);
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = we;
		wb_adr   = adr;
		wb_dat_w = data;
		@(negedge SYS_CLK);
		while (!wb_ack) @(negedge SYS_CLK);	// full fifo stretches this
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
	endtask

	task automatic wait_for_frames();
		while (mon.frames_pending() != 0) @(negedge SYS_CLK);
		repeat (CLK_DIV) @(negedge SYS_CLK);	// rest of the stop bit and back to idle
	endtask

	task automatic apply_entry(input int idx);
		uart_byte_t value;
		case (test_op[idx])
			op_line_idle: begin
				mon.check_line_idle(test_name[idx]);	// reset value of the line
			end
			op_wr_tx: begin
				mon.expect_frame(test_name[idx], test_val[idx][7:0]);
				bus_cycle(1'b1, reg_txdata, test_val[idx]);
			end
			op_wr_rand: begin
				random_byte(value);
				mon.expect_frame(test_name[idx], value);
				bus_cycle(1'b1, reg_txdata, {24'h0, value});
			end
			op_wr_other: begin
				bus_cycle(1'b1, 2'd2, test_val[idx]);
				repeat (FRAME_CYCLES) @(negedge SYS_CLK);
				mon.check_line_idle(test_name[idx]);
			end
			op_rd_active: begin
				mon.expect_read(test_name[idx], 1'b1, '0);
				bus_cycle(1'b0, reg_status, '0);
			end
			op_rd_other: begin
				mon.expect_read(test_name[idx], 1'b0, test_val[idx]);
				bus_cycle(1'b0, 2'd3, '0);
			end
			op_drain: begin
				wait_for_frames();
				mon.expect_read(test_name[idx], 1'b0, test_val[idx]);
				bus_cycle(1'b0, reg_status, '0);
			end
			default: begin
				mon.expect_read(test_name[idx], 1'b0, test_val[idx]);
				bus_cycle(1'b0, reg_status, '0);
			end
		endcase
	endtask

	initial begin : stimulus
		RST_N    = 1'b0;
		wb_cyc   = 1'b0;
		wb_stb   = 1'b0;
		wb_we    = 1'b0;
		wb_adr   = '0;
		wb_dat_w = '0;
		load_table();
		repeat (8) @(negedge SYS_CLK);
		RST_N = 1'b1;
		for (int i = 0; i < N_TESTS; i++) begin
			apply_entry(i);
		end
		wait_for_frames();
		$display("checks: %0d passed, %0d failed", mon.pass_count, mon.fail_count);
		if (mon.fail_count == 0 && mon.pass_count == N_TESTS) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	// one frame plus slack per entry
	initial begin : watchdog
		while (cycle_count < CYCLE_LIMIT) begin
			@(posedge SYS_CLK);
			cycle_count++;
		end
		$display("transmission stalled, run did not finish within %0d cycles", CYCLE_LIMIT);
		$display("Simulation failed");
		$finish;
	end

endmodule

/* sim/uart_monitor.sv */
`timescale 1ns/1ps

module uart_monitor import uart_pkg::*, wb_pkg::*; #(
	parameter int CLK_DIV = 8	// cycles per bit on txd
) (
	input logic     SYS_CLK,
	input logic     txd,
	input logic     wb_ack,
	input logic     wb_we,
	input wb_data_t wb_dat_r
);

	string      frame_name_q [$];	// queued by the stimulus in write order
	uart_byte_t frame_byte_q [$];
	string      rd_name_q    [$];
	logic       rd_any_q     [$];	// busy or not empty is enough
	wb_data_t   rd_value_q   [$];
	int         pass_count   = 0;
	int         fail_count   = 0;
	int         stray_frames = 0;	// frames nobody asked for
	logic       in_frame     = 1'b0;

	task automatic expect_frame(input string name, input uart_byte_t value);
		frame_name_q.push_back(name);
		frame_byte_q.push_back(value);
	endtask

	task automatic expect_read(input string name, input logic any, input wb_data_t value);
		rd_name_q.push_back(name);
		rd_any_q.push_back(any);
		rd_value_q.push_back(value);
	endtask

	function automatic int frames_pending();
		return frame_name_q.size();
	endfunction

	task automatic report_pass(input string name, input string what);
		pass_count++;
		$display("ok   %s: %s", name, what);
	endtask

	task automatic check_line_idle(input string name);
		if (in_frame || stray_frames != 0 || txd !== 1'b1) begin
			fail_count++;
			$display("%s: txd was not idle high or carried a frame that nobody queued", name);
		end else begin
			report_pass(name, "txd stayed high");
		end
	endtask

	task automatic check_frame(input uart_byte_t got, input logic start_ok, input logic stop_ok);
		string      name;
		uart_byte_t want;
		if (frame_name_q.size() == 0) begin
			stray_frames++;
			fail_count++;
			$display("unexpected frame on txd carrying 0x%02h", got);
		end else begin
			name = frame_name_q.pop_front();
			want = frame_byte_q.pop_front();
			if (!start_ok || !stop_ok) begin
				fail_count++;
				$display("%s: frame has a bad start or stop bit", name);
			end else if (got !== want) begin
				fail_count++;
				$display("Mismatch %s: expected 0x%02h, actual 0x%02h", name, want, got);
			end else begin
				report_pass(name, $sformatf("frame 0x%02h", got));
			end
		end
	endtask

	task automatic check_read(input wb_data_t got);
		string    name;
		logic     any;
		wb_data_t want;
		if (rd_name_q.size() == 0) begin
			fail_count++;
			$display("read acknowledged with nothing queued, data 0x%08h", got);
		end else begin
			name = rd_name_q.pop_front();
			any  = rd_any_q.pop_front();
			want = rd_value_q.pop_front();
			if (any && (got[stat_busy] || !got[stat_empty])) begin
				report_pass(name, $sformatf("status 0x%08h shows work pending", got));
			end else if (any) begin
				fail_count++;
				$display("Mismatch %s: expected busy or not empty, actual 0x%08h", name, got);
			end else if (got !== want) begin
				fail_count++;
				$display("Mismatch %s: expected 0x%08h, actual 0x%08h", name, want, got);
			end else begin
				report_pass(name, $sformatf("read 0x%08h", got));
			end
		end
	endtask

	// --------------------------------------------------
	// txd frame decoder locked to the start edge
	// --------------------------------------------------

	initial begin : frame_decode
		uart_byte_t got;
		logic       start_ok;
		logic       stop_ok;
		forever begin
			@(negedge txd);
			in_frame = 1'b1;
			repeat (CLK_DIV / 2) @(negedge SYS_CLK);	// to mid start bit
			start_ok = (txd === 1'b0);
			for (int i = 0; i < 8; i++) begin
				repeat (CLK_DIV) @(negedge SYS_CLK);
				got[i] = txd;	// lsb arrives first
			end
			repeat (CLK_DIV) @(negedge SYS_CLK);
			stop_ok  = (txd === 1'b1);
			in_frame = 1'b0;
			check_frame(got, start_ok, stop_ok);
		end
	end

	// read data is stable with ack and sampled mid cycle
	initial begin : bus_watch
		logic ack_seen;
		ack_seen = 1'b0;
		forever begin
			@(negedge SYS_CLK);
			if (wb_ack && ack_seen) begin
				fail_count++;
				$display("wb_ack stayed high for more than one cycle");
			end
			if (wb_ack && !wb_we) begin
				check_read(wb_dat_r);
			end
			ack_seen = wb_ack;	// single cycle pulse expected
		end
	end

endmodule
